// File: Makefile
SIM       := verilator
TOP       := exec_tb
RTL_TOP   := exec_top
FILELIST  := files.f
SIM_FLAGS := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := SOME TESTS FAILED

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: common/rv_pkg.sv
package rv_pkg;

    localparam int xlen    = 32;   // word width, fixed by rv32i
    localparam int reg_cnt = 32;   // architectural integer registers

    // major opcodes kept in the execute stage, isa encodings
    typedef enum logic [6:0] {
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,    // signed less than, 1 or 0
        alu_sltu,   // unsigned less than, 1 or 0
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    typedef enum logic [2:0] {
        kind_alu,          // register write-back
        kind_load_addr,    // value holds effective address
        kind_store_addr,   // value holds effective address
        kind_branch,
        kind_jump,         // jal and jalr
        kind_illegal       // anything outside the kept set
    } kind_e;

    // input channel payload
    typedef struct packed {
        logic [xlen-1:0] instr;
        logic [xlen-1:0] pc;
    } instr_req_t;

    // result record offered downstream
    typedef struct packed {
        kind_e           kind;
        logic [4:0]      rd;
        logic            wb_en;     // set only when rd was written
        logic [xlen-1:0] value;     // wb value or effective address
        logic [xlen-1:0] next_pc;   // resolved fetch address
    } exec_rsp_t;

endpackage

// File: files.f
common/rv_pkg.sv
src/imm_gen.sv
src/alu.sv
src/reg_file.sv
src/exec_ctrl.sv
src/exec_top.sv
verif/exec_sva.sv
verif/exec_tb.sv

// File: src/alu.sv
`timescale 1ns/100ps

module alu import rv_pkg::*; (
    input  alu_op_e         op,
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    output logic [xlen-1:0] result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];   // rv32i shifts use low five bits only

    always_comb begin
        case (op)
            alu_add: begin
                result = a + b;
            end
            alu_sub: begin
                result = a - b;
            end
            alu_sll: begin
                result = a << shamt;
            end
            alu_slt: begin
                result = {31'b0, $signed(a) < $signed(b)};
            end
            alu_sltu: begin
                result = {31'b0, a < b};
            end
            alu_xor: begin
                result = a ^ b;
            end
            alu_srl: begin
                result = a >> shamt;
            end
            alu_sra: begin
                result = $unsigned($signed(a) >>> shamt);   // fills with sign bit
            end
            alu_or: begin
                result = a | b;
            end
            alu_and: begin
                result = a & b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: src/exec_ctrl.sv
`timescale 1ns/100ps

module exec_ctrl import rv_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  instr_req_t      in_req,
    input  logic            in_valid,
    output logic            in_ready,
    output exec_rsp_t       out_rsp,
    output logic            out_valid,
    input  logic            out_ready,
    output logic [4:0]      rs1_addr,
    output logic [4:0]      rs2_addr,
    input  logic [xlen-1:0] rs1_data,
    input  logic [xlen-1:0] rs2_data,
    output logic            wr_en,
    output logic [4:0]      wr_addr,
    output logic [xlen-1:0] wr_data,
    output logic [xlen-1:0] imm_instr,
    input  logic [xlen-1:0] imm_value,
    output alu_op_e         alu_op,
    output logic [xlen-1:0] alu_a,
    output logic [xlen-1:0] alu_b,
    input  logic [xlen-1:0] alu_result
);

    logic [xlen-1:0] instr;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_plus4;
    opcode_e         opcode;
    logic [2:0]      func3;
    logic [4:0]      rd;
    logic            accept;
    logic            taken;
    exec_rsp_t       rsp_d;

    // func3 to alu op, alt picks sub or sra
    function automatic alu_op_e decode_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign instr    = in_req.instr;
    assign pc       = in_req.pc;
    assign pc_plus4 = pc + 32'd4;   // link value and fall-through
    assign opcode   = opcode_e'(instr[6:0]);
    assign func3    = instr[14:12];
    assign rd       = instr[11:7];

    assign rs1_addr  = instr[19:15];
    assign rs2_addr  = instr[24:20];
    assign imm_instr = instr;

    // one-entry output stage, refills as the old result leaves
    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    always_comb begin
        alu_op        = alu_add;
        alu_a         = rs1_data;
        alu_b         = imm_value;
        taken         = 1'b0;
        rsp_d.kind    = kind_illegal;
        rsp_d.rd      = rd;
        rsp_d.wb_en   = 1'b0;
        rsp_d.value   = alu_result;
        rsp_d.next_pc = pc_plus4;
        case (opcode)
            opc_op: begin
                alu_op      = decode_op(func3, instr[30]);
                alu_b       = rs2_data;
                rsp_d.kind  = kind_alu;
                rsp_d.wb_en = 1'b1;
            end
            opc_op_imm: begin
                alu_op      = decode_op(func3, instr[30] && func3 == 3'b101);   // no subi
                rsp_d.kind  = kind_alu;
                rsp_d.wb_en = 1'b1;
            end
            opc_lui: begin
                alu_a       = '0;   // value is the bare u-immediate
                rsp_d.kind  = kind_alu;
                rsp_d.wb_en = 1'b1;
            end
            opc_auipc: begin
                alu_a       = pc;
                rsp_d.kind  = kind_alu;
                rsp_d.wb_en = 1'b1;
            end
            opc_load: begin
                rsp_d.kind = kind_load_addr;   // rs1 + imm
            end
            opc_store: begin
                rsp_d.kind = kind_store_addr;
            end
            opc_jal: begin
                alu_a         = pc;
                rsp_d.kind    = kind_jump;
                rsp_d.wb_en   = 1'b1;
                rsp_d.value   = pc_plus4;
                rsp_d.next_pc = alu_result;
            end
            opc_jalr: begin
                rsp_d.kind    = kind_jump;
                rsp_d.wb_en   = 1'b1;
                rsp_d.value   = pc_plus4;
                rsp_d.next_pc = {alu_result[xlen-1:1], 1'b0};   // target bit 0 cleared
            end
            opc_branch: begin
                alu_op      = func3[1] ? alu_sltu : alu_slt;   // lt / ltu compare
                alu_b       = rs2_data;
                rsp_d.kind  = kind_branch;
                rsp_d.value = '0;
                case (func3)
                    3'b000:  taken = rs1_data == rs2_data;   // beq, local compare
                    3'b001:  taken = rs1_data != rs2_data;
                    3'b100:  taken = alu_result[0];
                    3'b101:  taken = !alu_result[0];
                    3'b110:  taken = alu_result[0];
                    3'b111:  taken = !alu_result[0];
                    default: rsp_d.kind = kind_illegal;   // func3 010 / 011 undefined
                endcase
                if (taken) begin
                    rsp_d.next_pc = pc + imm_value;
                end
            end
            default: begin
                rsp_d.value = '0;   // illegal, no write-back
            end
        endcase
        if (rd == 5'd0) begin
            rsp_d.wb_en = 1'b0;   // x0 writes are dropped
        end
    end

    // write-back lands on the accepting edge with the result load
    assign wr_en   = accept && rsp_d.wb_en;
    assign wr_addr = rd;
    assign wr_data = rsp_d.value;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;   // drained, nothing new
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_rsp <= rsp_d;   // held under back-pressure
        end
    end

endmodule

// File: src/exec_top.sv
`timescale 1ns/100ps

module exec_top import rv_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  instr_req_t in_req,
    input  logic       in_valid,
    output logic       in_ready,
    output exec_rsp_t  out_rsp,
    output logic       out_valid,
    input  logic       out_ready
);

    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic            wr_en;
    logic [4:0]      wr_addr;
    logic [xlen-1:0] wr_data;
    logic [xlen-1:0] imm_instr;
    logic [xlen-1:0] imm_value;
    alu_op_e         alu_op;
    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_result;

    exec_ctrl u_ctrl (   // handshake, decode, result register
        .clk        (clk),
        .arst_n     (arst_n),
        .in_req     (in_req),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .out_rsp    (out_rsp),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .imm_instr  (imm_instr),
        .imm_value  (imm_value),
        .alu_op     (alu_op),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_result (alu_result)
    );

    imm_gen u_imm_gen (
        .instruction (imm_instr),
        .immediate   (imm_value)
    );

    alu u_alu (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

endmodule

// File: src/imm_gen.sv
`timescale 1ns/100ps

module imm_gen import rv_pkg::*; (
    input  logic [xlen-1:0] instruction,
    output logic [xlen-1:0] immediate
);

    opcode_e    opcode;
    logic [2:0] func3;
    logic       sign;

    assign opcode = opcode_e'(instruction[6:0]);   // unknown codes fall to default
    assign func3  = instruction[14:12];
    assign sign   = instruction[31];                // every format signs from bit 31

    always_comb begin
        case (opcode)
            opc_load, opc_jalr: begin   // i-type
                immediate = {{20{sign}}, instruction[31:20]};
            end
            opc_op_imm: begin
                if (func3 == 3'b001 || func3 == 3'b101) begin
                    immediate = {27'b0, instruction[24:20]};   // shamt, zero extended
                end else begin
                    immediate = {{20{sign}}, instruction[31:20]};
                end
            end
            opc_store: begin   // s-type, split field
                immediate = {{20{sign}}, instruction[31:25], instruction[11:7]};
            end
            opc_branch: begin   // b-type, bit 0 implied zero
                immediate = {{20{sign}}, instruction[7], instruction[30:25],
                             instruction[11:8], 1'b0};
            end
            opc_jal: begin   // j-type
                immediate = {{12{sign}}, instruction[19:12], instruction[20],
                             instruction[30:21], 1'b0};
            end
            opc_lui, opc_auipc: begin   // u-type, low 12 bits clear
                immediate = {instruction[31:12], 12'b0};
            end
            default: begin
                immediate = '0;   // r-type and illegal carry no immediate
            end
        endcase
    end

endmodule

// File: src/reg_file.sv
`timescale 1ns/100ps

module reg_file import rv_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic [4:0]      rs1_addr,
    input  logic [4:0]      rs2_addr,
    output logic [xlen-1:0] rs1_data,
    output logic [xlen-1:0] rs2_data,
    input  logic            wr_en,
    input  logic [4:0]      wr_addr,
    input  logic [xlen-1:0] wr_data
);

    logic [xlen-1:0] regs [reg_cnt];

    // x0 reads zero regardless of storage
    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < reg_cnt; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != 5'd0) begin   // x0 ignores writes
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

// File: verif/exec_sva.sv
`timescale 1ns/100ps

module exec_sva import rv_pkg::*; (
    input logic       clk,
    input logic       arst_n,
    input logic       in_ready,
    input logic       out_valid,
    input logic       out_ready,
    input exec_rsp_t  out_rsp,
    input logic       wr_en,
    input logic [4:0] wr_addr
);

    a_reset_idle: assert property (@(posedge clk) !arst_n |-> !out_valid)
        else $error("out_valid high while in reset");

    // record frozen while the sink stalls
    a_hold_stable: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_rsp))
        else $error("result record changed under back-pressure");

    a_ready_rule: assert property (@(posedge clk) disable iff (!arst_n)
        in_ready == (!out_valid || out_ready))
        else $error("in_ready does not follow the one-entry rule");

    a_no_x0_write: assert property (@(posedge clk) disable iff (!arst_n)
        wr_en |-> wr_addr != 5'd0)
        else $error("register write fired for x0");

endmodule

bind exec_ctrl exec_sva u_sva (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_rsp   (out_rsp),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr)
);

// File: verif/exec_tb.sv
`timescale 1ns/100ps

module exec_tb import rv_pkg::*; ();

    logic       clk;
    logic       arst_n;
    instr_req_t in_req;
    logic       in_valid;
    logic       in_ready;
    exec_rsp_t  out_rsp;
    logic       out_valid;
    logic       out_ready;

    instr_req_t      stim_q[$];          // waiting to be offered
    string           name_q[$];
    exec_rsp_t       exp_q[$];           // accepted, result not yet seen
    string           exp_name_q[$];
    logic [xlen-1:0] shadow [reg_cnt];   // model register file, x0 never written
    logic [xlen-1:0] stim_pc;
    logic            bp_mode;            // random out_ready when set
    logic            timed_out;
    int              errors  = 0;
    int              checked = 0;
    int              acc_cnt = 0;
    int              out_cnt = 0;

    exec_top uut (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_req    (in_req),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_rsp   (out_rsp),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    // instruction encoders
    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
    endfunction

    function automatic logic [31:0] b_word(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_word(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
    endfunction

    // rv32i func3 semantics, alt is instruction bit 30
    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // expected record, updates the shadow registers
    function automatic exec_rsp_t predict(input instr_req_t req);
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic [2:0]  f3;
        logic        taken;
        exec_rsp_t   r;
        ins   = req.instr;
        f3    = ins[14:12];
        a     = shadow[ins[19:15]];
        b     = shadow[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u = {ins[31:12], 12'b0};
        imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        taken     = 1'b0;
        r.kind    = kind_illegal;   // unless a kept opcode matches
        r.rd      = ins[11:7];
        r.wb_en   = 1'b0;
        r.value   = '0;
        r.next_pc = req.pc + 32'd4;
        case (ins[6:0])
            opc_op: begin
                r.kind  = kind_alu;
                r.wb_en = 1'b1;
                r.value = alu_model(f3, ins[30], a, b);
            end
            opc_op_imm: begin
                r.kind  = kind_alu;
                r.wb_en = 1'b1;
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    r.value = alu_model(f3, ins[30], a, {27'b0, ins[24:20]});   // shamt
                end else begin
                    r.value = alu_model(f3, 1'b0, a, imm_i);   // no subi
                end
            end
            opc_lui: begin
                r.kind  = kind_alu;
                r.wb_en = 1'b1;
                r.value = imm_u;
            end
            opc_auipc: begin
                r.kind  = kind_alu;
                r.wb_en = 1'b1;
                r.value = req.pc + imm_u;
            end
            opc_load: begin
                r.kind  = kind_load_addr;
                r.value = a + imm_i;
            end
            opc_store: begin
                r.kind  = kind_store_addr;
                r.value = a + imm_s;
            end
            opc_branch: begin
                r.kind = kind_branch;
                case (f3)
                    3'd0:    taken = a == b;
                    3'd1:    taken = a != b;
                    3'd4:    taken = $signed(a) < $signed(b);
                    3'd5:    taken = $signed(a) >= $signed(b);
                    3'd6:    taken = a < b;
                    3'd7:    taken = a >= b;
                    default: r.kind = kind_illegal;   // reserved func3
                endcase
                if (taken) begin
                    r.next_pc = req.pc + imm_b;
                end
            end
            opc_jal: begin
                r.kind    = kind_jump;
                r.wb_en   = 1'b1;
                r.value   = req.pc + 32'd4;   // link
                r.next_pc = req.pc + imm_j;
            end
            opc_jalr: begin
                r.kind    = kind_jump;
                r.wb_en   = 1'b1;
                r.value   = req.pc + 32'd4;
                r.next_pc = (a + imm_i) & ~32'd1;
            end
            default: begin
            end
        endcase
        if (r.rd == 5'd0) begin
            r.wb_en = 1'b0;
        end
        if (r.wb_en) begin
            shadow[r.rd] = r.value;
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checked++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic send(input string name, input logic [31:0] instr);
        instr_req_t req;
        req.instr = instr;
        req.pc    = stim_pc;
        stim_q.push_back(req);
        name_q.push_back(name);
        stim_pc = stim_pc + 32'd4;
    endtask

    task automatic send_random_alu();
        logic [2:0] f3;
        logic       alt;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] shamt;
        f3    = 3'($urandom_range(7, 0));
        alt   = 1'($urandom_range(1, 0));
        rd    = 5'($urandom_range(7, 0));   // small set, many dependencies
        rs1   = 5'($urandom_range(7, 0));
        rs2   = 5'($urandom_range(7, 0));
        shamt = 5'($urandom);
        if ($urandom_range(1, 0) == 1) begin
            send("r-type alu", r_word({1'b0, alt && (f3 == 3'd0 || f3 == 3'd5), 5'b0},
                                      rs2, rs1, f3, rd));
        end else if (f3 == 3'd1 || f3 == 3'd5) begin
            send("shift imm", i_word({1'b0, alt && f3 == 3'd5, 5'b0, shamt}, rs1, f3, rd,
                                     opc_op_imm));
        end else begin
            send("alu imm", i_word(12'($urandom), rs1, f3, rd, opc_op_imm));
        end
    endtask

    task automatic send_random_branch();
        logic [2:0] f3;
        f3 = 3'($urandom_range(7, 0));
        if (f3[2:1] == 2'b01) begin
            f3 = 3'd0;   // keep to the six defined conditions
        end
        send("random branch", b_word({12'($urandom), 1'b0}, 5'($urandom_range(7, 0)),
                                     5'($urandom_range(7, 0)), f3));
    endtask

    // waits until every sent instruction has left the DUT
    task automatic drain(input string phase);
        int cycles;
        cycles = 0;
        while (!timed_out && (stim_q.size() != 0 || exp_q.size() != 0 || in_valid
                              || out_valid)) begin
            @(negedge clk);   // queues and valids settled after the edge
            cycles++;
            if (cycles > 4000) begin
                $display("timeout: phase %s did not drain within 4000 cycles", phase);
                errors++;
                timed_out = 1'b1;
            end
        end
    endtask

    initial begin : driver
        string cur_name;
        cur_name = "";
        in_valid <= 1'b0;
        in_req   <= '0;
        for (int i = 0; i < reg_cnt; i++) begin
            shadow[i] = '0;
        end
        forever begin
            @(posedge clk);
            if (arst_n && in_valid && in_ready) begin   // transfer on this edge
                exp_q.push_back(predict(in_req));
                exp_name_q.push_back(cur_name);
                acc_cnt++;
            end
            if (!in_valid || in_ready) begin
                if (stim_q.size() != 0) begin
                    in_req   <= stim_q.pop_front();
                    cur_name = name_q.pop_front();
                    in_valid <= 1'b1;
                end else begin
                    in_valid <= 1'b0;
                end
            end
        end
    end

    initial begin : sink
        out_ready <= 1'b1;
        forever begin
            @(posedge clk);
            out_ready <= bp_mode ? 1'($urandom_range(1, 0)) : 1'b1;
        end
    end

    initial begin : compare
        exec_rsp_t exp;
        string     nm;
        logic      acc_prev;
        acc_prev = 1'b0;
        forever begin
            @(posedge clk);
            if (acc_prev) begin
                check_value("out_valid one cycle after accept", 32'd1, {31'b0, out_valid});
            end
            acc_prev = arst_n && in_valid && in_ready;
            if (arst_n && out_valid && out_ready) begin
                out_cnt++;
                if (exp_q.size() == 0) begin
                    $display("unexpected result: the DUT offered a record with none pending");
                    errors++;
                end else begin
                    exp = exp_q.pop_front();
                    nm  = exp_name_q.pop_front();
                    check_value({nm, " kind"}, {29'b0, exp.kind}, {29'b0, out_rsp.kind});
                    check_value({nm, " rd"}, {27'b0, exp.rd}, {27'b0, out_rsp.rd});
                    check_value({nm, " wb_en"}, {31'b0, exp.wb_en}, {31'b0, out_rsp.wb_en});
                    check_value({nm, " value"}, exp.value, out_rsp.value);
                    check_value({nm, " next_pc"}, exp.next_pc, out_rsp.next_pc);
                end
            end
        end
    end

    initial begin : main
        void'($urandom(32'hbe0c));
        bp_mode   = 1'b0;
        timed_out = 1'b0;
        stim_pc   = 32'h0000_1000;
        arst_n <= 1'b0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_value("reset out_valid", 32'd0, {31'b0, out_valid});
        check_value("reset in_ready", 32'd1, {31'b0, in_ready});
        send("first addi", i_word(12'h9a5, 5'd0, 3'd0, 5'd1, opc_op_imm));   // negative imm
        drain("first addi");

        for (int r = 2; r < 8; r++) begin
            send("preload addi", i_word(12'($urandom), 5'd0, 3'd0, 5'(r), opc_op_imm));
        end
        send("write x0", i_word(12'h123, 5'd1, 3'd0, 5'd0, opc_op_imm));
        send("read x0", r_word(7'd0, 5'd0, 5'd0, 3'd0, 5'd6));   // x0 must still be zero
        for (int i = 0; i < 80; i++) begin
            send_random_alu();
        end
        drain("alu sequences");

        for (int i = 0; i < 32; i++) begin
            case (i % 4)
                0: send("lui", u_word(20'($urandom), 5'($urandom_range(7, 0)), opc_lui));
                1: send("auipc", u_word(20'($urandom), 5'($urandom_range(7, 0)), opc_auipc));
                2: send("load address", i_word(12'($urandom), 5'($urandom_range(7, 0)),
                                               3'($urandom_range(5, 0)), 5'($urandom), opc_load));
                default: send("store address", s_word(12'($urandom), 5'($urandom_range(7, 0)),
                                                      5'($urandom_range(7, 0)), 3'd2));
            endcase
        end
        drain("upper immediates and addresses");

        send("set x1", i_word(12'hffb, 5'd0, 3'd0, 5'd1, opc_op_imm));   // -5
        send("set x2", i_word(12'h003, 5'd0, 3'd0, 5'd2, opc_op_imm));
        send("set x3", i_word(12'hffb, 5'd0, 3'd0, 5'd3, opc_op_imm));
        for (int f = 0; f < 8; f++) begin
            if (f == 2 || f == 3) begin
                continue;
            end
            send("branch x1 x2 forward", b_word(13'h0040, 5'd2, 5'd1, 3'(f)));
            send("branch x2 x1 backward", b_word(13'h1ff0, 5'd1, 5'd2, 3'(f)));
            send("branch x1 x3 far back", b_word(13'h1000, 5'd3, 5'd1, 3'(f)));
        end
        send("jal forward", j_word(21'h000800, 5'd5));
        send("read link", r_word(7'd0, 5'd0, 5'd5, 3'd0, 5'd9));
        send("jal backward x0", j_word(21'h1ffff0, 5'd0));
        send("jalr even", i_word(12'h00d, 5'd1, 3'd0, 5'd7, opc_jalr));
        send("jalr odd target", i_word(12'h000, 5'd2, 3'd0, 5'd8, opc_jalr));
        send("jalr negative", i_word(12'hff8, 5'd2, 3'd0, 5'd0, opc_jalr));
        drain("branches and jumps");

        bp_mode = 1'b1;
        for (int i = 0; i < 120; i++) begin
            if ($urandom_range(3, 0) == 0) begin
                send_random_branch();
            end else begin
                send_random_alu();
            end
        end
        drain("back-pressure");
        bp_mode = 1'b0;

        send("illegal fence", {25'($urandom), 7'b0001111});
        send("illegal system", {25'($urandom), 7'b1110011});
        send("illegal zero", 32'h0000_0000);
        send("illegal ones", 32'hffff_ffff);
        send("illegal amo", {25'($urandom), 7'b0101111});
        send("branch func3 010", b_word(13'h0010, 5'd2, 5'd1, 3'd2));
        drain("illegal opcodes");

        check_value("results out vs accepted", acc_cnt, out_cnt);
        check_value("results still pending", 32'd0, exp_q.size());
        $display("checks: %0d, errors: %0d", checked, errors);
        if (errors == 0 && !timed_out) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
